// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tlb_mmu_tb \
    -f tlb_mmu_top.f \
    -o sim_tlb_mmu

out="$(./obj_dir/sim_tlb_mmu)"
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// ==== tlb_csr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_csr_ctrl import tlb_pkg::*; #(
    parameter int TLBNUM = tlb_num_default
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire apb_req_t                apb_req,
    input  wire tlb_entry_t              r_entry,
    output apb_rsp_t                     apb_rsp,
    output logic                         we,
    output logic [$clog2(TLBNUM)-1:0]    w_index,
    output logic [$clog2(TLBNUM)-1:0]    r_index,
    output tlb_entry_t                   w_entry,
    output inv_req_t                     inv
);

    localparam int idx_w = $clog2(TLBNUM);

    // staging registers
    logic [18:0]      hi_vppn;
    logic             hi_huge;
    logic [9:0]       asid_q;
    page_attr_t       lo0_q;
    page_attr_t       lo1_q;
    logic [idx_w-1:0] index_q;
    logic             ne_q;

    logic             access;
    logic             wr_acc;
    logic             mapped;
    logic             cmd_acc;
    logic             rd_cmd;
    cmd_e             cmd;
    logic [31:0]      rdata;

    function automatic page_attr_t lo_from_word(logic [31:0] w);
        page_attr_t p;
        p.v   = w[0];
        p.d   = w[1];
        p.plv = w[3:2];
        p.mat = w[5:4];
        p.g   = w[6];
        p.ppn = w[27:8];
        return p;
    endfunction

    function automatic logic [31:0] lo_to_word(page_attr_t p);
        return {4'b0, p.ppn, 1'b0, p.g, p.mat, p.plv, p.d, p.v};
    endfunction

    assign access  = apb_req.psel && apb_req.penable;
    assign wr_acc  = access && apb_req.pwrite;
    assign mapped  = apb_req.paddr inside {reg_entryhi, reg_asid, reg_lo0, reg_lo1,
                                           reg_index, reg_cmd};
    assign cmd_acc = wr_acc && (apb_req.paddr == reg_cmd);
    assign cmd     = cmd_e'(apb_req.pwdata[1:0]);
    assign rd_cmd  = cmd_acc && (cmd == cmd_read);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            hi_vppn <= '0;
            hi_huge <= 1'b0;
            asid_q  <= '0;
            lo0_q   <= '0;
            lo1_q   <= '0;
            index_q <= '0;
            ne_q    <= 1'b0;
        end else if (rd_cmd) begin
            // tlbrd image with g copied into both halves
            hi_vppn <= r_entry.vppn;
            hi_huge <= r_entry.huge;
            asid_q  <= r_entry.asid;
            lo0_q   <= r_entry.lo0;
            lo1_q   <= r_entry.lo1;
            lo0_q.g <= r_entry.g;
            lo1_q.g <= r_entry.g;
            ne_q    <= !r_entry.e;
        end else if (wr_acc) begin
            case (apb_req.paddr)
                reg_entryhi: begin
                    hi_vppn <= apb_req.pwdata[31:13];
                    hi_huge <= apb_req.pwdata[0];
                end
                reg_asid:  asid_q <= apb_req.pwdata[9:0];
                reg_lo0:   lo0_q  <= lo_from_word(apb_req.pwdata);
                reg_lo1:   lo1_q  <= lo_from_word(apb_req.pwdata);
                reg_index: begin
                    index_q <= apb_req.pwdata[idx_w-1:0];
                    ne_q    <= apb_req.pwdata[31];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        case (apb_req.paddr)
            reg_entryhi: rdata = {hi_vppn, 12'b0, hi_huge};
            reg_asid:    rdata[9:0] = asid_q;
            reg_lo0:     rdata = lo_to_word(lo0_q);
            reg_lo1:     rdata = lo_to_word(lo1_q);
            reg_index: begin
                rdata[31]        = ne_q;
                rdata[idx_w-1:0] = index_q;
            end
            default: ;
        endcase
    end

    always_comb begin
        apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : 32'b0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !mapped;
    end

    // tlbwr image where g is the AND of both halves
    always_comb begin
        w_entry.e    = !ne_q;
        w_entry.vppn = hi_vppn;
        w_entry.huge = hi_huge;
        w_entry.asid = asid_q;
        w_entry.g    = lo0_q.g && lo1_q.g;
        w_entry.lo0  = lo0_q;
        w_entry.lo1  = lo1_q;
    end

    assign we      = cmd_acc && (cmd == cmd_write);
    assign w_index = index_q;
    assign r_index = index_q;

    always_comb begin
        inv.valid = cmd_acc && (cmd == cmd_inv);
        inv.op    = apb_req.pwdata[8:4];
        inv.asid  = asid_q;
        inv.vppn  = hi_vppn;
        inv.huge  = hi_huge;
    end

endmodule

`default_nettype wire

// ==== tlb_entry_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_array import tlb_pkg::*; #(
    parameter int TLBNUM = tlb_num_default
) (
    input  wire                                 clk,
    input  wire                                 rstn,
    input  wire                                 we,
    input  wire        [$clog2(TLBNUM)-1:0]     w_index,
    input  wire tlb_entry_t                     w_entry,
    input  wire        [$clog2(TLBNUM)-1:0]     r_index,
    input  wire inv_req_t                       inv,
    output tlb_entry_t                          r_entry,
    output tlb_entry_t [TLBNUM-1:0]             entries
);

    localparam int idx_w = $clog2(TLBNUM);

    // payload storage and the separate exist bits
    tlb_entry_t [TLBNUM-1:0] store;
    logic       [TLBNUM-1:0] exist;
    logic       [TLBNUM-1:0] inv_hit;

    for (genvar i = 0; i < TLBNUM; i++) begin : g_entry
        logic is_g;
        logic asid_eq;
        logic va_eq;
        logic w_sel;

        assign w_sel   = we && (w_index == idx_w'(i));
        assign is_g    = store[i].g;
        assign asid_eq = (inv.asid == store[i].asid);
        // full vppn plus page size
        assign va_eq   = (inv.vppn == store[i].vppn) && (inv.huge == store[i].huge);

        always_comb begin
            case (inv.op)
                inv_all0,
                inv_all1:            inv_hit[i] = 1'b1;
                inv_glob:            inv_hit[i] = is_g;
                inv_nglob:           inv_hit[i] = !is_g;
                inv_nglob_asid:      inv_hit[i] = !is_g && asid_eq;
                inv_nglob_asid_va:   inv_hit[i] = !is_g && asid_eq && va_eq;
                inv_glob_or_asid_va: inv_hit[i] = (is_g || asid_eq) && va_eq;
                // ops above 6 leave the table alone
                default:             inv_hit[i] = 1'b0;
            endcase
        end

        always_ff @(posedge clk) begin
            if (w_sel) begin
                store[i] <= w_entry;
            end
        end

        // write takes priority over invalidate
        always_ff @(posedge clk) begin
            if (!rstn) begin
                exist[i] <= 1'b0;
            end else if (w_sel) begin
                exist[i] <= w_entry.e;
            end else if (inv.valid && inv_hit[i]) begin
                exist[i] <= 1'b0;
            end
        end

        always_comb begin
            entries[i]   = store[i];
            entries[i].e = exist[i];
        end
    end

    assign r_entry = entries[r_index];

endmodule

`default_nettype wire

// ==== tlb_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup import tlb_pkg::*; #(
    parameter int TLBNUM = tlb_num_default
) (
    input  wire tlb_entry_t [TLBNUM-1:0] entries,
    input  wire lookup_req_t             req,
    output lookup_rsp_t                  rsp
);

    localparam int idx_w = $clog2(TLBNUM);

    logic [TLBNUM-1:0] match;
    logic [idx_w-1:0]  hit_idx;
    tlb_entry_t        hit;
    page_attr_t        half;
    logic              odd;

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            match[i] = entries[i].e
                && (entries[i].vppn[18:9] == req.vppn[18:9])
                && (entries[i].huge || (entries[i].vppn[8:0] == req.vppn[8:0]))
                && (entries[i].g || (entries[i].asid == req.asid));
        end
    end

    // lowest index wins
    always_comb begin
        hit_idx = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = idx_w'(i);
            end
        end
    end

    assign hit  = entries[hit_idx];
    // odd page bit sits at va[21] for 4 MB, va[12] for 4 KB
    assign odd  = hit.huge ? req.vppn[8] : req.va_bit12;
    assign half = odd ? hit.lo1 : hit.lo0;

    always_comb begin
        rsp = '0;
        if (|match) begin
            rsp.found = 1'b1;
            rsp.index = 4'(hit_idx);
            rsp.ppn   = half.ppn;
            rsp.ps    = hit.huge ? ps_4m : ps_4k;
            rsp.plv   = half.plv;
            rsp.mat   = half.mat;
            rsp.d     = half.d;
            rsp.v     = half.v;
        end
    end

endmodule

`default_nettype wire

// ==== tlb_mmu_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_mmu_sva import tlb_pkg::*; (
    input wire           clk,
    input wire           rstn,
    input wire apb_req_t apb_req,
    input wire apb_rsp_t apb_rsp,
    input wire           we
);

    int   fail_count = 0;
    logic mapped;

    // word offsets 0x00 up to the command register
    assign mapped = (apb_req.paddr[1:0] == 2'b00) && (apb_req.paddr <= reg_cmd);

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rstn)
        apb_req.penable |-> apb_req.psel)
        else begin
            fail_count = fail_count + 1;
            $error("penable high without psel");
        end

    // error response only in the access phase of an unmapped offset
    a_slverr_unmapped: assert property (@(posedge clk) disable iff (!rstn)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable && !mapped))
        else begin
            fail_count = fail_count + 1;
            $error("pslverr outside an unmapped access");
        end

    a_we_single: assert property (@(posedge clk) disable iff (!rstn)
        we |=> !we)
        else begin
            fail_count = fail_count + 1;
            $error("we high for two cycles");
        end

endmodule

bind tlb_csr_ctrl tlb_mmu_sva u_sva (
    .clk     (clk),
    .rstn    (rstn),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .we      (we)
);

`default_nettype wire

// ==== tlb_mmu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_mmu_tb import tlb_pkg::*;;

    typedef struct packed {
        logic [3:0]  idx;
        logic [18:0] vppn;
        logic        huge;
        logic [9:0]  asid;
        logic        g;
    } ent_row_t;

    // port 0 fetch, 1 data, 2 both
    typedef struct packed {
        logic [1:0]  port;
        logic [18:0] vppn;
        logic        b12;
        logic [9:0]  asid;
        logic        hit;
        logic [3:0]  idx;
    } lk_row_t;

    typedef struct packed {
        logic [4:0]  op;
        logic [18:0] vppn;
        logic        huge;
        logic [9:0]  asid;
    } inv_row_t;

    logic        clk = 1'b0;
    logic        rstn;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    lookup_req_t fetch_req;
    lookup_rsp_t fetch_rsp;
    lookup_req_t data_req;
    lookup_rsp_t data_rsp;

    ent_row_t    ent_tab [8];
    lk_row_t     lk_tab [14];
    inv_row_t    inv_tab [8];
    page_attr_t  row_lo0 [8];
    page_attr_t  row_lo1 [8];
    tlb_entry_t  model [16];
    logic [31:0] lfsr;
    int          errors;

    tlb_mmu_top #(.TLBNUM(16)) uut (
        .clk       (clk),
        .rstn      (rstn),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            errors++;
            $display("Fail %0t %s actual=%h expected=%h", $time, name, act, exp);
        end
    endtask

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic random_attr(output page_attr_t p);
        logic [31:0] v;
        p = '0;
        take_bits(20, v);
        p.ppn = v[19:0];
        take_bits(2, v);
        p.plv = v[1:0];
        take_bits(2, v);
        p.mat = v[1:0];
        take_bits(1, v);
        p.d = v[0];
        take_bits(1, v);
        p.v = v[0];
    endtask

    function automatic logic [31:0] lo_word(page_attr_t p);
        return {4'b0, p.ppn, 1'b0, p.g, p.mat, p.plv, p.d, p.v};
    endfunction

    function automatic logic [31:0] cmd_word(cmd_e c, logic [4:0] op);
        return {23'b0, op, 2'b0, c};
    endfunction

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        #5;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #5;
        apb_req.penable = 1'b1;
        #1;
        while (!apb_rsp.pready && waited < 20) begin
            @(posedge clk);
            #6;
            waited++;
        end
        if (!apb_rsp.pready) begin
            $display("pready never came for address %h at %0t", addr, $time);
            $display("TESTS FAILED");
            $finish;
        end else begin
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
            @(posedge clk);
            #5;
            apb_req = '0;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check($sformatf("pslverr wr %h", addr), 64'(err), 64'd0);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'd0, data, err);
        check($sformatf("pslverr rd %h", addr), 64'(err), 64'd0);
    endtask

    function automatic lookup_rsp_t model_lookup(lookup_req_t r);
        lookup_rsp_t o;
        page_attr_t  h;
        logic        same_page;
        o = '0;
        for (int i = 0; i < 16; i++) begin
            if (model[i].huge) begin
                same_page = model[i].vppn[18:9] == r.vppn[18:9];
            end else begin
                same_page = model[i].vppn == r.vppn;
            end
            if (!o.found && model[i].e && same_page && (model[i].g || model[i].asid == r.asid)) begin
                h = (model[i].huge ? r.vppn[8] : r.va_bit12) ? model[i].lo1 : model[i].lo0;
                o.found = 1'b1;
                o.index = 4'(i);
                o.ppn   = h.ppn;
                o.ps    = model[i].huge ? ps_4m : ps_4k;
                o.plv   = h.plv;
                o.mat   = h.mat;
                o.d     = h.d;
                o.v     = h.v;
            end
        end
        return o;
    endfunction

    task automatic model_invalidate(input inv_row_t v);
        logic hit;
        logic same_asid;
        logic same_va;
        for (int i = 0; i < 16; i++) begin
            same_asid = model[i].asid == v.asid;
            same_va   = (model[i].vppn == v.vppn) && (model[i].huge == v.huge);
            case (v.op)
                5'd0, 5'd1: hit = 1'b1;
                5'd2:       hit = model[i].g;
                5'd3:       hit = !model[i].g;
                5'd4:       hit = !model[i].g && same_asid;
                5'd5:       hit = !model[i].g && same_asid && same_va;
                5'd6:       hit = (model[i].g || same_asid) && same_va;
                default:    hit = 1'b0;
            endcase
            if (hit) begin
                model[i].e = 1'b0;
            end
        end
    endtask

    task automatic write_entry(input int r);
        ent_row_t   t;
        page_attr_t l0;
        page_attr_t l1;
        tlb_entry_t m;
        t = ent_tab[r];
        l0 = row_lo0[r];
        l1 = row_lo1[r];
        // row 1 gets a lone lo0.g, so its entry ends up non-global
        l0.g = t.g | (r == 1);
        l1.g = t.g;
        apb_write(reg_entryhi, {t.vppn, 12'b0, t.huge});
        apb_write(reg_asid, {22'b0, t.asid});
        apb_write(reg_lo0, lo_word(l0));
        apb_write(reg_lo1, lo_word(l1));
        apb_write(reg_index, {28'b0, t.idx});
        apb_write(reg_cmd, cmd_word(cmd_write, 5'd0));
        m.e    = 1'b1;
        m.vppn = t.vppn;
        m.huge = t.huge;
        m.asid = t.asid;
        m.g    = l0.g & l1.g;
        m.lo0  = l0;
        m.lo1  = l1;
        model[t.idx] = m;
    endtask

    task automatic load_table();
        for (int r = 0; r < 8; r++) begin
            write_entry(r);
        end
    endtask

    task automatic read_back(input logic [3:0] idx, input logic full);
        logic [31:0] rd;
        tlb_entry_t  m;
        page_attr_t  l0;
        page_attr_t  l1;
        m = model[idx];
        apb_write(reg_index, {28'b0, idx});
        apb_write(reg_cmd, cmd_word(cmd_read, 5'd0));
        apb_read(reg_index, rd);
        check($sformatf("index[%0d]", idx), 64'(rd), 64'({!m.e, 27'b0, idx}));
        if (full) begin
            // g comes back in both halves
            l0 = m.lo0;
            l0.g = m.g;
            l1 = m.lo1;
            l1.g = m.g;
            apb_read(reg_entryhi, rd);
            check($sformatf("entryhi[%0d]", idx), 64'(rd), 64'({m.vppn, 12'b0, m.huge}));
            apb_read(reg_asid, rd);
            check($sformatf("asid[%0d]", idx), 64'(rd), 64'({22'b0, m.asid}));
            apb_read(reg_lo0, rd);
            check($sformatf("lo0[%0d]", idx), 64'(rd), 64'(lo_word(l0)));
            apb_read(reg_lo1, rd);
            check($sformatf("lo1[%0d]", idx), 64'(rd), 64'(lo_word(l1)));
        end
    endtask

    task automatic run_lookups(input logic use_table);
        lk_row_t     row;
        lookup_req_t req;
        lookup_req_t idle;
        lookup_rsp_t act;
        idle = {19'h7ffff, 1'b0, 10'h3ff};
        for (int r = 0; r < 14; r++) begin
            row = lk_tab[r];
            req = {row.vppn, row.b12, row.asid};
            @(posedge clk);
            #5;
            fetch_req = (row.port != 2'd1) ? req : idle;
            data_req  = (row.port != 2'd0) ? req : idle;
            #10;
            check($sformatf("fetch_rsp row %0d", r), 64'(fetch_rsp), 64'(model_lookup(fetch_req)));
            check($sformatf("data_rsp row %0d", r), 64'(data_rsp), 64'(model_lookup(data_req)));
            if (use_table) begin
                act = (row.port == 2'd1) ? data_rsp : fetch_rsp;
                check($sformatf("hit index row %0d", r), 64'({act.found, act.index}),
                      64'({row.hit, row.hit ? row.idx : 4'd0}));
            end
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        int          sva_fails;
        apb_req   = '0;
        fetch_req = '0;
        data_req  = '0;
        rstn      = 1'b0;
        errors    = 0;
        lfsr      = 32'h6bfd_0717;
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end

        ent_tab = '{
            '{4'd0, 19'h01234, 1'b0, 10'h011, 1'b0},
            '{4'd1, 19'h01235, 1'b0, 10'h011, 1'b0},
            '{4'd2, 19'h04a00, 1'b1, 10'h011, 1'b0},
            '{4'd3, 19'h04a7f, 1'b1, 10'h011, 1'b0},
            '{4'd4, 19'h20040, 1'b0, 10'h022, 1'b1},
            '{4'd5, 19'h31000, 1'b1, 10'h022, 1'b1},
            '{4'd6, 19'h01234, 1'b0, 10'h033, 1'b0},
            '{4'd7, 19'h70001, 1'b0, 10'h011, 1'b0}
        };
        // 4 MB rows 5, 6, 9 and 10 pick the half by vppn bit 8
        lk_tab = '{
            '{2'd2, 19'h01234, 1'b0, 10'h011, 1'b1, 4'd0},
            '{2'd0, 19'h01234, 1'b1, 10'h011, 1'b1, 4'd0},
            '{2'd1, 19'h01235, 1'b1, 10'h011, 1'b1, 4'd1},
            '{2'd2, 19'h01234, 1'b0, 10'h033, 1'b1, 4'd6},
            '{2'd2, 19'h01234, 1'b0, 10'h044, 1'b0, 4'd0},
            '{2'd2, 19'h04a3c, 1'b0, 10'h011, 1'b1, 4'd2},
            '{2'd1, 19'h04bc5, 1'b1, 10'h011, 1'b1, 4'd2},
            '{2'd0, 19'h04a12, 1'b0, 10'h022, 1'b0, 4'd0},
            '{2'd2, 19'h20040, 1'b1, 10'h3ff, 1'b1, 4'd4},
            '{2'd0, 19'h311ff, 1'b0, 10'h000, 1'b1, 4'd5},
            '{2'd1, 19'h31055, 1'b1, 10'h000, 1'b1, 4'd5},
            '{2'd2, 19'h70001, 1'b0, 10'h011, 1'b1, 4'd7},
            '{2'd0, 19'h70001, 1'b0, 10'h012, 1'b0, 4'd0},
            '{2'd2, 19'h55555, 1'b0, 10'h011, 1'b0, 4'd0}
        };
        inv_tab = '{
            '{5'd0, 19'h00000, 1'b0, 10'h000},
            '{5'd1, 19'h00000, 1'b0, 10'h000},
            '{5'd2, 19'h00000, 1'b0, 10'h000},
            '{5'd3, 19'h00000, 1'b0, 10'h000},
            '{5'd4, 19'h00000, 1'b0, 10'h011},
            '{5'd5, 19'h01234, 1'b0, 10'h011},
            '{5'd6, 19'h20040, 1'b0, 10'h011},
            '{5'd7, 19'h01234, 1'b0, 10'h011}
        };
        for (int r = 0; r < 8; r++) begin
            random_attr(row_lo0[r]);
            random_attr(row_lo1[r]);
        end

        repeat (2) @(posedge clk);
        #5;
        rstn = 1'b1;

        // empty table after reset
        run_lookups(1'b0);
        for (int i = 0; i < 16; i++) begin
            read_back(4'(i), 1'b0);
        end
        apb_read(reg_cmd, rd);
        check("cmd readback", 64'(rd), 64'd0);

        load_table();
        for (int r = 0; r < 8; r++) begin
            read_back(ent_tab[r].idx, 1'b1);
        end
        run_lookups(1'b1);

        for (int k = 0; k < 8; k++) begin
            load_table();
            apb_write(reg_entryhi, {inv_tab[k].vppn, 12'b0, inv_tab[k].huge});
            apb_write(reg_asid, {22'b0, inv_tab[k].asid});
            apb_write(reg_cmd, cmd_word(cmd_inv, inv_tab[k].op));
            model_invalidate(inv_tab[k]);
            run_lookups(1'b0);
            for (int r = 0; r < 8; r++) begin
                read_back(ent_tab[r].idx, 1'b1);
            end
        end

        apb_xfer(1'b0, 8'h18, 32'd0, rd, err);
        check("pslverr unmapped rd", 64'(err), 64'd1);
        apb_xfer(1'b1, 8'h20, 32'hffff_ffff, rd, err);
        check("pslverr unmapped wr", 64'(err), 64'd1);

        sva_fails = uut.u_csr_ctrl.u_sva.fail_count;
        $display("errors: %0d  assertion failures: %0d", errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tlb_mmu_top.f ====
tlb_pkg.sv
tlb_entry_array.sv
tlb_lookup.sv
tlb_csr_ctrl.sv
tlb_mmu_top.sv
tlb_mmu_sva.sv
tlb_mmu_tb.sv

// ==== tlb_mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_mmu_top import tlb_pkg::*; #(
    parameter int TLBNUM = tlb_num_default
) (
    input  wire                clk,
    input  wire                rstn,
    input  wire apb_req_t      apb_req,
    output apb_rsp_t           apb_rsp,
    input  wire lookup_req_t   fetch_req,
    output lookup_rsp_t        fetch_rsp,
    input  wire lookup_req_t   data_req,
    output lookup_rsp_t        data_rsp
);

    logic                       we;
    logic [$clog2(TLBNUM)-1:0]  w_index;
    logic [$clog2(TLBNUM)-1:0]  r_index;
    tlb_entry_t                 w_entry;
    tlb_entry_t                 r_entry;
    inv_req_t                   inv;
    tlb_entry_t [TLBNUM-1:0]    entries;

    tlb_csr_ctrl #(.TLBNUM(TLBNUM)) u_csr_ctrl (
        .clk     (clk),
        .rstn    (rstn),
        .apb_req (apb_req),
        .r_entry (r_entry),
        .apb_rsp (apb_rsp),
        .we      (we),
        .w_index (w_index),
        .r_index (r_index),
        .w_entry (w_entry),
        .inv     (inv)
    );

    tlb_entry_array #(.TLBNUM(TLBNUM)) u_entry_array (
        .clk     (clk),
        .rstn    (rstn),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .inv     (inv),
        .r_entry (r_entry),
        .entries (entries)
    );

    // instruction fetch side
    tlb_lookup #(.TLBNUM(TLBNUM)) u_fetch_lookup (
        .entries (entries),
        .req     (fetch_req),
        .rsp     (fetch_rsp)
    );

    // load/store side
    tlb_lookup #(.TLBNUM(TLBNUM)) u_data_lookup (
        .entries (entries),
        .req     (data_req),
        .rsp     (data_rsp)
    );

endmodule

`default_nettype wire

// ==== tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

    localparam int tlb_num_default = 16;

    // page size codes returned on lookup
    localparam logic [5:0] ps_4m = 6'd21;
    localparam logic [5:0] ps_4k = 6'd12;

    // one half of a page pair
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
        // register image only
        logic        g;
    } page_attr_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic        huge;
        logic [9:0]  asid;
        logic        g;
        page_attr_t  lo0;
        page_attr_t  lo1;
    } tlb_entry_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic        va_bit12;
        logic [9:0]  asid;
    } lookup_req_t;

    typedef struct packed {
        logic        found;
        logic [3:0]  index;
        logic [19:0] ppn;
        logic [5:0]  ps;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } lookup_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  op;
        logic [9:0]  asid;
        logic [18:0] vppn;
        logic        huge;
    } inv_req_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        cmd_none  = 2'd0,
        cmd_write = 2'd1,
        cmd_read  = 2'd2,
        cmd_inv   = 2'd3
    } cmd_e;

    // invtlb ops
    localparam logic [4:0] inv_all0            = 5'd0;
    localparam logic [4:0] inv_all1            = 5'd1;
    localparam logic [4:0] inv_glob            = 5'd2;
    localparam logic [4:0] inv_nglob           = 5'd3;
    localparam logic [4:0] inv_nglob_asid      = 5'd4;
    localparam logic [4:0] inv_nglob_asid_va   = 5'd5;
    localparam logic [4:0] inv_glob_or_asid_va = 5'd6;

    // apb register map
    localparam logic [7:0] reg_entryhi = 8'h00;
    localparam logic [7:0] reg_asid    = 8'h04;
    localparam logic [7:0] reg_lo0     = 8'h08;
    localparam logic [7:0] reg_lo1     = 8'h0C;
    localparam logic [7:0] reg_index   = 8'h10;
    localparam logic [7:0] reg_cmd     = 8'h14;

endpackage

`default_nettype wire
